// File: project.f
+incdir+include
rtl/mapper_pkg.sv
rtl/page_cfg_if.sv
rtl/io_ports.sv
rtl/window_pager.sv
rtl/cpu_front.sv
rtl/zx_mapper.sv
test/tb_clock.sv
test/tb_zx_mapper.sv

// File: test/tb_zx_mapper.sv
`timescale 1ns/100ps
`default_nettype none

`include "mapper_defs.svh"

module tb_zx_mapper;

	localparam int MAX_STEPS = 40;

	logic                   fclk;
	logic                   rst_n;
	logic                   req_valid;
	logic                   req_ready;
	logic                   req_io;
	logic                   req_rnw;
	logic                   req_m1;
	logic [15:0]            req_addr;
	logic [7:0]             req_wdata;
	logic                   rsp_valid;
	logic                   rsp_ready = 1'b0;
	logic [7:0]             rsp_data;
	logic                   mem_valid;
	logic                   mem_ready = 1'b0;
	logic                   mem_rnw;
	logic                   mem_rom;
	logic [`MAP_PHYS_W-1:0] mem_addr;
	logic [7:0]             mem_wdata;
	logic                   mem_rvalid = 1'b0;
	logic [7:0]             mem_rdata = 8'h00;

	// one entry of stimulus and expected values per request
	logic                   t_io       [MAX_STEPS];
	logic                   t_rnw      [MAX_STEPS];
	logic                   t_m1       [MAX_STEPS];
	logic [15:0]            t_addr     [MAX_STEPS];
	logic [7:0]             t_wdata    [MAX_STEPS];
	logic [`MAP_PHYS_W-1:0] t_exp_addr [MAX_STEPS];
	logic                   t_exp_rom  [MAX_STEPS];
	logic [7:0]             t_exp_data [MAX_STEPS];
	int                     n_steps = 0;

	int                     errors = 0;
	int                     checks = 0;
	int                     cycles = 0;
	int                     limit = 1000;
	int                     mem_cnt = 0;
	int                     rsp_cnt = 0;
	int                     rd_req_cnt = 0;
	int                     rd_served = 0;
	int                     rd_delay = 0;
	logic                   rd_pending = 1'b0;
	logic [31:0]            lfsr_state = 32'h65fa01fa;

	// last memory handshake seen by the monitor
	logic [`MAP_PHYS_W-1:0] seen_addr;
	logic                   seen_rom;
	logic                   seen_rnw;
	logic [7:0]             seen_wdata;

	tb_clock u_clock (.fclk(fclk), .rst_n(rst_n));

	zx_mapper i_dut (
		.fclk(fclk), .rst_n(rst_n),
		.req_valid(req_valid), .req_ready(req_ready), .req_io(req_io),
		.req_rnw(req_rnw), .req_m1(req_m1), .req_addr(req_addr), .req_wdata(req_wdata),
		.rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp_data(rsp_data),
		.mem_valid(mem_valid), .mem_ready(mem_ready), .mem_rnw(mem_rnw),
		.mem_rom(mem_rom), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.mem_rvalid(mem_rvalid), .mem_rdata(mem_rdata)
	);

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////

	// x^32 + x^22 + x^2 + x + 1 Fibonacci LFSR
	function automatic logic [3:0] take_bits(input int n);
		logic [3:0] r;
		logic       b;
		r = '0;
		for (int k = 0; k < n; k++)
		begin
			b          = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], b};
			r          = {r[2:0], b};
		end
		return r;
	endfunction

	function automatic logic [`MAP_PHYS_W-1:0] phys_addr(input logic [7:0] page,
		input logic [15:0] addr);
		return {page, addr[`MAP_OFS_W-1:0]};
	endfunction

	// memory holds the low address byte XOR the page byte
	function automatic logic [7:0] mem_model(input logic [`MAP_PHYS_W-1:0] addr);
		return addr[7:0] ^ addr[`MAP_PHYS_W-1:`MAP_OFS_W];
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Error at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic add_mem(input logic rnw, input logic m1, input logic [15:0] addr,
		input logic [7:0] wdata, input logic [7:0] page, input logic rom);
		t_io[n_steps]       = 1'b0;
		t_rnw[n_steps]      = rnw;
		t_m1[n_steps]       = m1;
		t_addr[n_steps]     = addr;
		t_wdata[n_steps]    = wdata;
		t_exp_addr[n_steps] = phys_addr(page, addr);
		t_exp_rom[n_steps]  = rom;
		t_exp_data[n_steps] = mem_model(phys_addr(page, addr));
		n_steps++;
	endtask

	task automatic add_io(input logic rnw, input logic [15:0] addr,
		input logic [7:0] wdata, input logic [7:0] exp_data);
		t_io[n_steps]       = 1'b1;
		t_rnw[n_steps]      = rnw;
		t_m1[n_steps]       = 1'b0;
		t_addr[n_steps]     = addr;
		t_wdata[n_steps]    = wdata;
		t_exp_addr[n_steps] = '0;
		t_exp_rom[n_steps]  = 1'b0;
		t_exp_data[n_steps] = exp_data;
		n_steps++;
	endtask

	task automatic load_table();
		// Pentagon mapping after reset
		add_mem(1, 0, 16'h0123, 8'h00, 8'h00, 1);
		add_mem(1, 0, 16'h4567, 8'h00, 8'h05, 0);
		add_mem(1, 0, 16'h89AB, 8'h00, 8'h02, 0);
		add_mem(1, 0, 16'hCDEF, 8'h00, 8'h00, 0);
		// 7FFD paging and then its lock
		add_io(0, 16'h7FFD, 8'h13, 8'h00);
		add_mem(1, 0, 16'hC010, 8'h00, 8'h03, 0);
		add_mem(1, 0, 16'h0010, 8'h00, 8'h01, 1);
		add_io(0, 16'h7FFD, 8'h33, 8'h00);
		add_io(0, 16'h7FFD, 8'h04, 8'h00);
		add_mem(1, 0, 16'hC020, 8'h00, 8'h03, 0);
		add_mem(1, 0, 16'h0020, 8'h00, 8'h01, 1);
		add_io(1, 16'h7FFD, 8'h00, 8'hFF);
		// DOS on at 3Dxx and off again from window 2
		add_mem(1, 1, 16'h3D00, 8'h00, 8'h01, 1);
		add_mem(1, 0, 16'h0100, 8'h00, 8'h03, 1);
		add_mem(1, 1, 16'h8000, 8'h00, 8'h02, 0);
		add_mem(1, 0, 16'h0200, 8'h00, 8'h01, 1);
		// ATM mode and window remap
		add_io(0, 16'h0077, 8'h01, 8'h00);
		add_io(0, 16'h00F7, 8'hE6, 8'h00);
		add_io(0, 16'h60F7, 8'h1A, 8'h00);
		add_io(0, 16'h80F7, 8'hB4, 8'h00);
		add_io(0, 16'hE0F7, 8'h7C, 8'h00);
		add_mem(1, 0, 16'h0040, 8'h00, 8'h06, 1);
		add_mem(1, 0, 16'h5040, 8'h00, 8'h1A, 0);
		add_mem(1, 0, 16'h9ABC, 8'h00, 8'h14, 1);
		add_mem(1, 0, 16'hF00F, 8'h00, 8'h7C, 0);
		add_io(1, 16'h00F7, 8'h00, 8'hE6);
		add_io(1, 16'h40F7, 8'h00, 8'h1A);
		add_io(1, 16'hA0F7, 8'h00, 8'hB4);
		add_io(1, 16'hC0F7, 8'h00, 8'h7C);
		add_io(1, 16'h00FE, 8'h00, 8'hFF);
		// writes and reads under back-pressure
		add_mem(0, 0, 16'h4ABC, 8'h5A, 8'h1A, 0);
		add_mem(0, 0, 16'hC001, 8'hA5, 8'h7C, 0);
		add_mem(0, 0, 16'h2345, 8'h3C, 8'h06, 1);
		add_mem(1, 0, 16'hFFFF, 8'h00, 8'h7C, 0);
		add_mem(0, 0, 16'h8888, 8'hC3, 8'h14, 1);
		add_mem(1, 0, 16'h7FFF, 8'h00, 8'h1A, 0);
	endtask

	////////////////////////////////////////////////////////////
	// memory model and random ready
	////////////////////////////////////////////////////////////

	always @(posedge fclk)
	begin
		if (rst_n)
		begin
			#2;
			mem_rvalid = 1'b0;
			mem_ready  = (take_bits(2) != 0);
			rsp_ready  = (take_bits(2) != 0);
			if (!rd_pending && rd_served != rd_req_cnt)
			begin
				rd_pending = 1'b1;
				rd_delay   = take_bits(2);
			end
			if (rd_pending)
			begin
				if (rd_delay == 0)
				begin
					mem_rvalid = 1'b1;
					mem_rdata  = mem_model(seen_addr);
					rd_pending = 1'b0;
					rd_served++;
				end
				else
					rd_delay--;
			end
		end
	end

	// handshake monitor sampled mid-cycle
	always @(negedge fclk)
	begin
		if (rst_n && mem_valid && mem_ready)
		begin
			mem_cnt++;
			seen_addr  = mem_addr;
			seen_rom   = mem_rom;
			seen_rnw   = mem_rnw;
			seen_wdata = mem_wdata;
			if (mem_rnw)
				rd_req_cnt++;
		end
		if (rst_n && rsp_valid && rsp_ready)
			rsp_cnt++;
	end

	always @(posedge fclk)
	begin
		cycles++;
		if (cycles >= limit)
		begin
			$display("run stopped after %0d cycles, the DUT stopped answering", cycles);
			$display("Test failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		int step_errs;
		int exp_mem;
		req_valid = 1'b0;
		req_io    = 1'b0;
		req_rnw   = 1'b1;
		req_m1    = 1'b0;
		req_addr  = 16'h0000;
		req_wdata = 8'h00;
		exp_mem   = 0;
		load_table();
		limit = n_steps * 40 + 20;

		while (rst_n !== 1'b1)
			@(posedge fclk);
		@(negedge fclk);
		check_value("req_ready", req_ready, 1);
		check_value("rsp_valid", rsp_valid, 0);
		check_value("mem_valid", mem_valid, 0);
		@(posedge fclk);

		for (int i = 0; i < n_steps; i++)
		begin
			step_errs = errors;
			#2;
			req_valid = 1'b1;
			req_io    = t_io[i];
			req_rnw   = t_rnw[i];
			req_m1    = t_m1[i];
			req_addr  = t_addr[i];
			req_wdata = t_wdata[i];
			do
				@(negedge fclk);
			while (!req_ready);
			@(posedge fclk);
			#2 req_valid = 1'b0;

			do
				@(negedge fclk);
			while (!(rsp_valid && rsp_ready));
			if (t_rnw[i])
				check_value("rsp_data", rsp_data, t_exp_data[i]);
			if (!t_io[i])
			begin
				exp_mem++;
				check_value("mem_addr", seen_addr, t_exp_addr[i]);
				check_value("mem_rom", seen_rom, t_exp_rom[i]);
				check_value("mem_rnw", seen_rnw, t_rnw[i]);
				if (!t_rnw[i])
					check_value("mem_wdata", seen_wdata, t_wdata[i]);
			end
			@(posedge fclk);
			check_value("response count", rsp_cnt, i + 1);
			check_value("memory handshake count", mem_cnt, exp_mem);
			$display("step %0d: %s %s addr %h: %s", i, t_io[i] ? "io" : "mem",
				t_rnw[i] ? "read" : "write", t_addr[i],
				(errors == step_errs) ? "ok" : "mismatch");
		end

		$display("steps %0d, checks %0d, errors %0d", n_steps, checks, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: test/tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
	output logic fclk,
	output logic rst_n
);

	// 40 ns period
	initial
	begin
		fclk = 1'b0;
		forever #20 fclk = ~fclk;
	end

	// reset held over the first two rising edges
	initial
	begin
		rst_n = 1'b0;
		repeat (2) @(posedge fclk);
		#2 rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// File: rtl/zx_mapper.sv
`timescale 1ns/100ps
`default_nettype none

`include "mapper_defs.svh"

module zx_mapper (
	input  wire                    fclk,
	input  wire                    rst_n,
	input  wire                    req_valid,
	output logic                   req_ready,
	input  wire                    req_io,
	input  wire                    req_rnw,
	input  wire                    req_m1,
	input  wire [15:0]             req_addr,
	input  wire [7:0]              req_wdata,
	output logic                   rsp_valid,
	input  wire                    rsp_ready,
	output logic [7:0]             rsp_data,
	output logic                   mem_valid,
	input  wire                    mem_ready,
	output logic                   mem_rnw,
	output logic                   mem_rom,
	output logic [`MAP_PHYS_W-1:0] mem_addr,
	output logic [7:0]             mem_wdata,
	input  wire                    mem_rvalid,
	input  wire [7:0]              mem_rdata
);

	import mapper_pkg::*;

	page_word_u              win_page [`MAP_WIN_N];
	page_word_u              win_raw  [`MAP_WIN_N];
	logic [`MAP_WIN_N-1:0]   win_rom;
	logic [`MAP_WIN_N-1:0]   dos_on;
	logic [`MAP_WIN_N-1:0]   dos_off;
	logic                    fetch_stb;
	logic [15:0]             fetch_addr;
	logic                    io_stb;
	logic                    io_rnw;
	logic [15:0]             io_addr;
	logic [7:0]              io_wdata;
	logic [7:0]              io_rdata;

	page_cfg_if u_cfg ();

	cpu_front u_front (
		.fclk(fclk), .rst_n(rst_n),
		.req_valid(req_valid), .req_ready(req_ready), .req_io(req_io),
		.req_rnw(req_rnw), .req_m1(req_m1), .req_addr(req_addr), .req_wdata(req_wdata),
		.rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp_data(rsp_data),
		.mem_valid(mem_valid), .mem_ready(mem_ready), .mem_rnw(mem_rnw),
		.mem_rom(mem_rom), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.mem_rvalid(mem_rvalid), .mem_rdata(mem_rdata),
		.win_page(win_page), .win_rom(win_rom),
		.fetch_stb(fetch_stb), .fetch_addr(fetch_addr),
		.io_stb(io_stb), .io_rnw(io_rnw), .io_addr(io_addr),
		.io_wdata(io_wdata), .io_rdata(io_rdata)
	);

	io_ports u_ports (
		.fclk(fclk), .rst_n(rst_n),
		.io_stb(io_stb), .io_rnw(io_rnw), .io_addr(io_addr), .io_wdata(io_wdata),
		.dos_on(dos_on), .dos_off(dos_off), .win_raw(win_raw),
		.io_rdata(io_rdata), .cfg(u_cfg.cfg)
	);

	////////////////////////////////////////////////////////////
	// one pager per 16 KB window
	////////////////////////////////////////////////////////////

	for (genvar i = 0; i < `MAP_WIN_N; i++)
	begin : g_pager
		window_pager #(.WINDOW(i)) u_pager (
			.fclk(fclk), .rst_n(rst_n),
			.fetch_stb(fetch_stb), .fetch_addr(fetch_addr),
			.page(win_page[i]), .raw(win_raw[i]), .rom(win_rom[i]),
			.dos_on(dos_on[i]), .dos_off(dos_off[i]),
			.cfg(u_cfg.pager)
		);
	end

endmodule

`default_nettype wire

// File: rtl/cpu_front.sv
`timescale 1ns/100ps
`default_nettype none

`include "mapper_defs.svh"

module cpu_front (
	input  wire                      fclk,
	input  wire                      rst_n,
	// cpu request
	input  wire                      req_valid,
	output logic                     req_ready,
	input  wire                      req_io,
	input  wire                      req_rnw,
	input  wire                      req_m1,
	input  wire [15:0]               req_addr,
	input  wire [7:0]                req_wdata,
	// cpu response
	output logic                     rsp_valid,
	input  wire                      rsp_ready,
	output logic [7:0]               rsp_data,
	// memory side
	output logic                     mem_valid,
	input  wire                      mem_ready,
	output logic                     mem_rnw,
	output logic                     mem_rom,
	output logic [`MAP_PHYS_W-1:0]   mem_addr,
	output logic [7:0]               mem_wdata,
	input  wire                      mem_rvalid,
	input  wire [7:0]                mem_rdata,
	// mapping
	input  mapper_pkg::page_word_u   win_page [`MAP_WIN_N],
	input  wire [`MAP_WIN_N-1:0]     win_rom,
	output logic                     fetch_stb,
	output logic [15:0]              fetch_addr,
	// i/o ports
	output logic                     io_stb,
	output logic                     io_rnw,
	output logic [15:0]              io_addr,
	output logic [7:0]               io_wdata,
	input  wire [7:0]                io_rdata
);

	import mapper_pkg::*;

	typedef enum logic [1:0] {ST_IDLE, ST_MEM, ST_RDWAIT, ST_RSP} state_t;

	state_t                 state;
	logic                   accept;
	page_word_u             sel_page;
	logic                   sel_rom;
	logic [`MAP_PAGE_W-1:0] phys_page;

	logic                   rnw_q;
	logic                   rom_q;
	logic [`MAP_PHYS_W-1:0] addr_q;
	logic [7:0]             wdata_q;
	logic [7:0]             rdata_q;

	assign req_ready = (state == ST_IDLE);
	assign accept    = req_valid & req_ready;

	// strobes to the pagers and the port block at acceptance
	assign fetch_stb  = accept & ~req_io & req_m1;
	assign fetch_addr = req_addr;
	assign io_stb     = accept & req_io;
	assign io_rnw     = req_rnw;
	assign io_addr    = req_addr;
	assign io_wdata   = req_wdata;

	// translation through the selected window
	always_comb
	begin
		sel_page = win_page[req_addr[15:`MAP_OFS_W]];
		sel_rom  = win_rom[req_addr[15:`MAP_OFS_W]];
		if (sel_rom)
			phys_page = {{(`MAP_PAGE_W-`MAP_ROMPG_W){1'b0}}, sel_page.rom.page};
		else
			phys_page = sel_page.ram;
	end

	////////////////////////////////////////////////////////////
	// request FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
			state <= ST_IDLE;
		else
		begin
			case (state)
				ST_IDLE:
					if (accept)
						state <= req_io ? ST_RSP : ST_MEM;
				ST_MEM:
					if (mem_ready)
						state <= rnw_q ? ST_RDWAIT : ST_RSP;
				ST_RDWAIT:
					if (mem_rvalid)
						state <= ST_RSP;
				default:
					if (rsp_ready)
						state <= ST_IDLE;
			endcase
		end
	end

	// captured request, address frozen before any DOS change lands
	always_ff @(posedge fclk)
	begin
		if (accept)
		begin
			rnw_q   <= req_rnw;
			rom_q   <= sel_rom;
			addr_q  <= {phys_page, req_addr[`MAP_OFS_W-1:0]};
			wdata_q <= req_wdata;
			// port read byte, don't care for a write
			if (req_io)
				rdata_q <= io_rdata;
		end
		else if (state == ST_RDWAIT && mem_rvalid)
			rdata_q <= mem_rdata;
	end

	assign mem_valid = (state == ST_MEM);
	assign mem_rnw   = rnw_q;
	assign mem_rom   = rom_q;
	assign mem_addr  = addr_q;
	assign mem_wdata = wdata_q;

	assign rsp_valid = (state == ST_RSP);
	assign rsp_data  = rdata_q;

endmodule

`default_nettype wire

// File: rtl/window_pager.sv
`timescale 1ns/100ps
`default_nettype none

`include "mapper_defs.svh"

module window_pager #(
	parameter int WINDOW = 0
) (
	input  wire                     fclk,
	input  wire                     rst_n,
	input  wire                     fetch_stb,
	input  wire [15:0]              fetch_addr,
	output mapper_pkg::page_word_u  page,
	output mapper_pkg::page_word_u  raw,
	output logic                    rom,
	output logic                    dos_on,
	output logic                    dos_off,
	page_cfg_if.pager               cfg
);

	import mapper_pkg::*;

	localparam logic [`MAP_WIN_W-1:0] WIN_SEL = WINDOW[`MAP_WIN_W-1:0];

	page_word_u raw_q;
	logic       ram_q;
	logic       fetch_hit;

	// stored ATM page and its RAM/ROM bit
	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			raw_q <= `MAP_PAGE_RST;
			ram_q <= 1'b0;
		end
		else if (cfg.wr_en && cfg.wr_window == WIN_SEL)
		begin
			raw_q <= cfg.wr_data;
			ram_q <= cfg.wr_ram;
		end
	end

	assign raw = raw_q;

	// effective page
	always_comb
	begin
		page = raw_q;
		rom  = ~ram_q;
		if (!cfg.atm_en)
		begin
			case (WINDOW)
				0:
				begin
					// ROM page = dos*2 + 7FFD bit 4
					page.rom.unused = '0;
					page.rom.page   = {{(`MAP_ROMPG_W-2){1'b0}}, cfg.dos, cfg.p7ffd[4]};
					rom             = 1'b1;
				end
				1:
				begin
					page.ram = `MAP_PENT_W1;
					rom      = 1'b0;
				end
				2:
				begin
					page.ram = `MAP_PENT_W2;
					rom      = 1'b0;
				end
				default:
				begin
					page.ram = {{(`MAP_PAGE_W-3){1'b0}}, cfg.p7ffd[2:0]};
					rom      = 1'b0;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// DOS on/off detection on opcode fetch
	////////////////////////////////////////////////////////////

	assign fetch_hit = fetch_stb && (fetch_addr[15:`MAP_OFS_W] == WIN_SEL);

	assign dos_on  = (WINDOW == 0) && fetch_hit && rom && (fetch_addr[15:8] == `MAP_DOS_HI);
	assign dos_off = (WINDOW != 0) && fetch_hit;

endmodule

`default_nettype wire

// File: rtl/io_ports.sv
`timescale 1ns/100ps
`default_nettype none

`include "mapper_defs.svh"

module io_ports (
	input  wire                     fclk,
	input  wire                     rst_n,
	input  wire                     io_stb,
	input  wire                     io_rnw,
	input  wire [15:0]              io_addr,
	input  wire [7:0]               io_wdata,
	input  wire [`MAP_WIN_N-1:0]    dos_on,
	input  wire [`MAP_WIN_N-1:0]    dos_off,
	input  mapper_pkg::page_word_u  win_raw [`MAP_WIN_N],
	output logic [7:0]              io_rdata,
	page_cfg_if.cfg                 cfg
);

	import mapper_pkg::*;

	logic                   io_wr;
	logic                   hit_7ffd;
	logic                   hit_cfg;
	logic                   hit_atm;

	logic [7:0]             p7ffd_q;
	logic                   atm_en_q;
	logic                   dos_q;
	logic                   wr_en_q;
	logic [`MAP_WIN_W-1:0]  wr_window_q;
	logic                   wr_ram_q;
	logic [`MAP_PAGE_W-1:0] wr_data_q;

	////////////////////////////////////////////////////////////
	// port decode
	////////////////////////////////////////////////////////////

	assign io_wr    = io_stb & ~io_rnw;
	assign hit_7ffd = (io_addr == `MAP_PORT_7FFD);
	assign hit_cfg  = (io_addr[7:0] == `MAP_PORT_CFG);
	assign hit_atm  = (io_addr[7:0] == `MAP_PORT_ATM);

	////////////////////////////////////////////////////////////
	// mapping state
	////////////////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (!rst_n)
		begin
			p7ffd_q  <= 8'h00;
			atm_en_q <= 1'b0;
			dos_q    <= 1'b0;
			wr_en_q  <= 1'b0;
		end
		else
		begin
			// 7FFD stays frozen once its lock bit is set
			if (io_wr && hit_7ffd && !p7ffd_q[`MAP_P7FFD_LOCK])
				p7ffd_q <= io_wdata;
			if (io_wr && hit_cfg)
				atm_en_q <= io_wdata[0];
			// turn-off wins over turn-on
			if (|dos_off)
				dos_q <= 1'b0;
			else if (|dos_on)
				dos_q <= 1'b1;
			wr_en_q <= io_wr & hit_atm;
		end
	end

	// page write payload, window from A15:14, RAM/ROM from A13
	always_ff @(posedge fclk)
	begin
		if (io_wr && hit_atm)
		begin
			wr_window_q <= io_addr[15:`MAP_OFS_W];
			wr_ram_q    <= io_addr[13];
			wr_data_q   <= io_wdata;
		end
	end

	assign cfg.wr_en     = wr_en_q;
	assign cfg.wr_window = wr_window_q;
	assign cfg.wr_ram    = wr_ram_q;
	assign cfg.wr_data   = wr_data_q;
	assign cfg.atm_en    = atm_en_q;
	assign cfg.dos       = dos_q;
	assign cfg.p7ffd     = p7ffd_q;

	// read back of the raw page register, unused ports float high
	assign io_rdata = hit_atm ? win_raw[io_addr[15:`MAP_OFS_W]].ram : 8'hFF;

endmodule

`default_nettype wire

// File: rtl/page_cfg_if.sv
`timescale 1ns/100ps
`default_nettype none

`include "mapper_defs.svh"

interface page_cfg_if;

	// page register write, one cycle wide
	logic                   wr_en;
	logic [`MAP_WIN_W-1:0]  wr_window;
	logic                   wr_ram;
	logic [`MAP_PAGE_W-1:0] wr_data;

	// global mapping state
	logic                   atm_en;
	logic                   dos;
	logic [7:0]             p7ffd;

	modport cfg (
		output wr_en, wr_window, wr_ram, wr_data, atm_en, dos, p7ffd
	);

	modport pager (
		input wr_en, wr_window, wr_ram, wr_data, atm_en, dos, p7ffd
	);

endinterface

`default_nettype wire

// File: rtl/mapper_pkg.sv
`default_nettype none

`include "mapper_defs.svh"

package mapper_pkg;

	// ROM view: upper bits unused, low bits select the ROM page
	typedef struct packed {
		logic [`MAP_PAGE_W-`MAP_ROMPG_W-1:0] unused;
		logic [`MAP_ROMPG_W-1:0]             page;
	} rom_view_t;

	typedef union packed {
		logic [`MAP_PAGE_W-1:0] ram;
		rom_view_t              rom;
	} page_word_u;

endpackage

`default_nettype wire

// File: include/mapper_defs.svh
`ifndef MAPPER_DEFS_SVH
`define MAPPER_DEFS_SVH

// address windows of 16 KB each
`define MAP_WIN_N       4
`define MAP_WIN_W       2
`define MAP_OFS_W       14

// page register and physical address
`define MAP_PAGE_W      8
`define MAP_PHYS_W      22
`define MAP_ROMPG_W     5
`define MAP_PAGE_RST    8'h00

// port decode
`define MAP_PORT_ATM    8'hF7
`define MAP_PORT_CFG    8'h77
`define MAP_PORT_7FFD   16'h7FFD
`define MAP_P7FFD_LOCK  5

// high address byte of the DOS entry points
`define MAP_DOS_HI      8'h3D

// fixed RAM pages of windows 1 and 2 in Pentagon mode
`define MAP_PENT_W1     8'd5
`define MAP_PENT_W2     8'd2

`endif
